//--- rv_pkg.sv
package rv_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // One data word, also the address width
  localparam int xlen = 32;

  // Register address field
  localparam int reg_addr_w = 5;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes known to the core
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_other  = 7'b0000000
  } opcode_e;

  // ALU operations, coded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add    = 4'b0000,
    alu_sub    = 4'b1000,
    alu_sll    = 4'b0001,
    alu_slt    = 4'b0010,
    alu_sltu   = 4'b0011,
    alu_xor    = 4'b0100,
    alu_srl    = 4'b0101,
    alu_sra    = 4'b1101,
    alu_or     = 4'b0110,
    alu_and    = 4'b0111,
    alu_pass_b = 4'b1111   // LUI only
  } alu_op_e;

  // Branch conditions as found in funct3
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_cond_e;

endpackage

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  we_i,
  input  logic [reg_addr_w-1:0] waddr_i,
  input  logic [xlen-1:0]       wdata_i,
  input  logic [reg_addr_w-1:0] raddr1_i,
  input  logic [reg_addr_w-1:0] raddr2_i,
  output logic [xlen-1:0]       rdata1_o,
  output logic [xlen-1:0]       rdata2_o
);

  // No storage for x0
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode
  import rv_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  logic [xlen-1:0]       instr_i,
  input  logic                  flush_i,
  input  logic [xlen-1:0]       target_i,
  output logic                  valid_o,
  output logic [xlen-1:0]       pc_o,
  output alu_op_e               alu_op_o,
  output logic [reg_addr_w-1:0] rd_o,
  output logic [reg_addr_w-1:0] rs1_o,
  output logic [reg_addr_w-1:0] rs2_o,
  output logic [xlen-1:0]       imm_o,
  output logic                  imm_sel_o,
  output logic                  branch_o,
  output branch_cond_e          cond_o
);

  logic [xlen-1:0]       pc;
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic                  alt;
  logic [xlen-1:0]       imm_i_type;
  logic [xlen-1:0]       imm_u_type;
  logic [xlen-1:0]       imm_b_type;
  alu_op_e               dec_alu_op;
  logic [reg_addr_w-1:0] dec_rd;
  logic [xlen-1:0]       dec_imm;
  logic                  dec_imm_sel;
  logic                  dec_branch;

  assign funct3 = instr_i[14:12];
  assign alt    = instr_i[30];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};

  // Anything outside the supported groups retires as a no-op
  always_comb begin
    opcode = opcode_e'(instr_i[6:0]);
    if (!(opcode inside {opc_op, opc_op_imm, opc_lui, opc_branch})) begin
      opcode = opc_other;
    end
  end

  always_comb begin
    dec_alu_op  = alu_add;
    dec_rd      = instr_i[11:7];
    dec_imm     = imm_i_type;
    dec_imm_sel = 1'b0;
    dec_branch  = 1'b0;
    case (opcode)
      opc_op: begin
        // funct7[5] only selects SUB and SRA
        dec_alu_op = alu_op_e'({alt & (funct3 == 3'b000 || funct3 == 3'b101), funct3});
      end
      opc_op_imm: begin
        dec_alu_op  = alu_op_e'({alt & (funct3 == 3'b101), funct3});
        dec_imm_sel = 1'b1;
      end
      opc_lui: begin
        dec_alu_op  = alu_pass_b;
        dec_imm     = imm_u_type;
        dec_imm_sel = 1'b1;
      end
      opc_branch: begin
        dec_alu_op = alu_sub;
        dec_rd     = '0;
        dec_imm    = imm_b_type;
        // funct3 010 and 011 are not branches
        dec_branch = (funct3[2:1] != 2'b01);
      end
      default: begin
        dec_rd = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc        <= reset_pc;
      valid_o   <= 1'b0;
      pc_o      <= '0;
      alu_op_o  <= alu_add;
      rd_o      <= '0;
      rs1_o     <= '0;
      rs2_o     <= '0;
      imm_o     <= '0;
      imm_sel_o <= 1'b0;
      branch_o  <= 1'b0;
      cond_o    <= br_beq;
    end else if (flush_i) begin
      // Strobe in the flush cycle is dropped
      valid_o <= 1'b0;
      pc      <= target_i;
    end else begin
      valid_o <= instr_valid_i;
      if (instr_valid_i) begin
        pc        <= pc + 32'd4;
        pc_o      <= pc;
        alu_op_o  <= dec_alu_op;
        rd_o      <= dec_rd;
        rs1_o     <= instr_i[19:15];
        rs2_o     <= instr_i[24:20];
        imm_o     <= dec_imm;
        imm_sel_o <= dec_imm_sel;
        branch_o  <= dec_branch;
        cond_o    <= branch_cond_e'(funct3);
      end
    end
  end

endmodule

//--- rv_opfetch.sv
`timescale 1ns/1ps

module rv_opfetch
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  flush_i,
  input  logic                  valid_i,
  input  alu_op_e               alu_op_i,
  input  logic [reg_addr_w-1:0] rd_i,
  input  logic [reg_addr_w-1:0] rs1_i,
  input  logic [reg_addr_w-1:0] rs2_i,
  input  logic [xlen-1:0]       imm_i,
  input  logic                  imm_sel_i,
  input  logic                  branch_i,
  input  branch_cond_e          cond_i,
  input  logic [xlen-1:0]       pc_i,
  input  logic [xlen-1:0]       rdata1_i,
  input  logic [xlen-1:0]       rdata2_i,
  input  logic                  ex_valid_i,
  input  logic [reg_addr_w-1:0] ex_rd_i,
  input  logic [xlen-1:0]       ex_result_i,
  input  logic [reg_addr_w-1:0] wb_rd_i,
  input  logic [xlen-1:0]       wb_data_i,
  output logic                  valid_o,
  output logic [xlen-1:0]       op_a_o,
  output logic [xlen-1:0]       op_b_o,
  output alu_op_e               alu_op_o,
  output logic [reg_addr_w-1:0] rd_o,
  output logic                  branch_o,
  output branch_cond_e          cond_o,
  output logic [xlen-1:0]       pc_o,
  output logic [xlen-1:0]       imm_o,
  output logic [reg_addr_w-1:0] raddr1_o,
  output logic [reg_addr_w-1:0] raddr2_o
);

  logic [reg_addr_w-1:0] rs1_q;
  logic [reg_addr_w-1:0] rs2_q;
  logic [xlen-1:0]       src1_q;
  logic [xlen-1:0]       src2_q;
  logic                  imm_sel_q;

  // Writeback data ahead of the register file for a nonzero rd
  function automatic logic [xlen-1:0] wb_bypass(logic [reg_addr_w-1:0] rs,
                                                logic [xlen-1:0] rdata);
    if (wb_rd_i != '0 && wb_rd_i == rs) begin
      return wb_data_i;
    end
    return rdata;
  endfunction

  function automatic logic [xlen-1:0] forward(logic [reg_addr_w-1:0] rs,
                                              logic [xlen-1:0] src);
    if (ex_valid_i && ex_rd_i != '0 && ex_rd_i == rs) begin
      return ex_result_i;
    end
    return wb_bypass(rs, src);
  endfunction

  assign raddr1_o = rs1_i;
  assign raddr2_o = rs2_i;

  ////////////////////
  // Stage register
  ////////////////////

  // Capture picks up the instruction three ahead as it writes back
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o   <= 1'b0;
      rs1_q     <= '0;
      rs2_q     <= '0;
      src1_q    <= '0;
      src2_q    <= '0;
      imm_sel_q <= 1'b0;
      alu_op_o  <= alu_add;
      rd_o      <= '0;
      branch_o  <= 1'b0;
      cond_o    <= br_beq;
      pc_o      <= '0;
      imm_o     <= '0;
    end else begin
      valid_o <= valid_i && !flush_i;
      if (valid_i) begin
        rs1_q     <= rs1_i;
        rs2_q     <= rs2_i;
        src1_q    <= wb_bypass(rs1_i, rdata1_i);
        src2_q    <= wb_bypass(rs2_i, rdata2_i);
        imm_sel_q <= imm_sel_i;
        alu_op_o  <= alu_op_i;
        rd_o      <= rd_i;
        branch_o  <= branch_i;
        cond_o    <= cond_i;
        pc_o      <= pc_i;
        imm_o     <= imm_i;
      end
    end
  end

  ////////////////////
  // Operand select
  ////////////////////

  // The next older result only exists in the execute register now
  assign op_a_o = forward(rs1_q, src1_q);
  assign op_b_o = imm_sel_q ? imm_o : forward(rs2_q, src2_q);

endmodule

//--- rv_alu.sv
`timescale 1ns/1ps

module rv_alu
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  flush_i,
  input  logic                  valid_i,
  input  logic [xlen-1:0]       op_a_i,
  input  logic [xlen-1:0]       op_b_i,
  input  alu_op_e               alu_op_i,
  input  logic [reg_addr_w-1:0] rd_i,
  input  logic                  branch_i,
  input  branch_cond_e          cond_i,
  input  logic [xlen-1:0]       pc_i,
  input  logic [xlen-1:0]       imm_i,
  output logic                  valid_o,
  output logic [xlen-1:0]       result_o,
  output logic                  equal_o,
  output logic                  less_o,
  output logic                  less_signed_o,
  output logic [reg_addr_w-1:0] rd_o,
  output logic                  branch_o,
  output branch_cond_e          cond_o,
  output logic [xlen-1:0]       pc_o,
  output logic [xlen-1:0]       imm_o
);

  logic [xlen-1:0] result;
  logic [4:0]      shamt;
  logic            less;
  logic            less_signed;

  assign shamt       = op_b_i[4:0];
  assign less        = op_a_i < op_b_i;
  assign less_signed = $signed(op_a_i) < $signed(op_b_i);

  always_comb begin
    case (alu_op_i)
      alu_add:    result = op_a_i + op_b_i;
      alu_sub:    result = op_a_i - op_b_i;
      alu_sll:    result = op_a_i << shamt;
      alu_slt:    result = {31'b0, less_signed};
      alu_sltu:   result = {31'b0, less};
      alu_xor:    result = op_a_i ^ op_b_i;
      alu_srl:    result = op_a_i >> shamt;
      alu_sra:    result = $unsigned($signed(op_a_i) >>> shamt);
      alu_or:     result = op_a_i | op_b_i;
      alu_and:    result = op_a_i & op_b_i;
      alu_pass_b: result = op_b_i;
      default:    result = op_a_i + op_b_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o       <= 1'b0;
      result_o      <= '0;
      equal_o       <= 1'b0;
      less_o        <= 1'b0;
      less_signed_o <= 1'b0;
      rd_o          <= '0;
      branch_o      <= 1'b0;
      cond_o        <= br_beq;
      pc_o          <= '0;
      imm_o         <= '0;
    end else begin
      valid_o <= valid_i && !flush_i;
      if (valid_i) begin
        result_o      <= result;
        equal_o       <= op_a_i == op_b_i;
        less_o        <= less;
        less_signed_o <= less_signed;
        rd_o          <= rd_i;
        branch_o      <= branch_i;
        cond_o        <= cond_i;
        pc_o          <= pc_i;
        imm_o         <= imm_i;
      end
    end
  end

endmodule

//--- rv_writeback.sv
`timescale 1ns/1ps

module rv_writeback
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  input  logic [xlen-1:0]       result_i,
  input  logic                  equal_i,
  input  logic                  less_i,
  input  logic                  less_signed_i,
  input  logic [reg_addr_w-1:0] rd_i,
  input  logic                  branch_i,
  input  branch_cond_e          cond_i,
  input  logic [xlen-1:0]       pc_i,
  input  logic [xlen-1:0]       imm_i,
  output logic                  wb_valid_o,
  output logic [xlen-1:0]       wb_pc_o,
  output logic [reg_addr_w-1:0] wb_rd_o,
  output logic [xlen-1:0]       wb_data_o,
  output logic                  reg_we_o,
  output logic                  branch_taken_o,
  output logic [xlen-1:0]       branch_target_o
);

  logic valid;
  logic cond_met;

  assign valid = valid_i && !branch_taken_o;

  always_comb begin
    case (cond_i)
      br_beq:  cond_met = equal_i;
      br_bne:  cond_met = !equal_i;
      br_blt:  cond_met = less_signed_i;
      br_bge:  cond_met = !less_signed_i;
      br_bltu: cond_met = less_i;
      br_bgeu: cond_met = !less_i;
      default: cond_met = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_o      <= 1'b0;
      wb_pc_o         <= '0;
      wb_rd_o         <= '0;
      wb_data_o       <= '0;
      branch_taken_o  <= 1'b0;
      branch_target_o <= '0;
    end else begin
      wb_valid_o      <= valid;
      wb_pc_o         <= pc_i;
      wb_rd_o         <= valid ? rd_i : '0;
      wb_data_o       <= result_i;
      branch_taken_o  <= valid && branch_i && cond_met;
      branch_target_o <= pc_i + imm_i;
    end
  end

  assign reg_we_o = wb_valid_o && (wb_rd_o != '0);

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  logic [xlen-1:0]       instr_i,
  output logic                  wb_valid_o,
  output logic [xlen-1:0]       wb_pc_o,
  output logic [reg_addr_w-1:0] wb_rd_o,
  output logic [xlen-1:0]       wb_data_o,
  output logic                  branch_taken_o,
  output logic [xlen-1:0]       branch_target_o
);

  // Decode to opfetch
  logic                  dec_valid;
  logic [xlen-1:0]       dec_pc;
  alu_op_e               dec_alu_op;
  logic [reg_addr_w-1:0] dec_rd;
  logic [reg_addr_w-1:0] dec_rs1;
  logic [reg_addr_w-1:0] dec_rs2;
  logic [xlen-1:0]       dec_imm;
  logic                  dec_imm_sel;
  logic                  dec_branch;
  branch_cond_e          dec_cond;

  // Register file ports
  logic [reg_addr_w-1:0] rf_raddr1;
  logic [reg_addr_w-1:0] rf_raddr2;
  logic [xlen-1:0]       rf_rdata1;
  logic [xlen-1:0]       rf_rdata2;
  logic                  rf_we;

  // Opfetch to alu
  logic                  of_valid;
  logic [xlen-1:0]       of_op_a;
  logic [xlen-1:0]       of_op_b;
  alu_op_e               of_alu_op;
  logic [reg_addr_w-1:0] of_rd;
  logic                  of_branch;
  branch_cond_e          of_cond;
  logic [xlen-1:0]       of_pc;
  logic [xlen-1:0]       of_imm;

  // Alu to writeback
  logic                  ex_valid;
  logic [xlen-1:0]       ex_result;
  logic                  ex_equal;
  logic                  ex_less;
  logic                  ex_less_signed;
  logic [reg_addr_w-1:0] ex_rd;
  logic                  ex_branch;
  branch_cond_e          ex_cond;
  logic [xlen-1:0]       ex_pc;
  logic [xlen-1:0]       ex_imm;

  rv_decode #(
    .reset_pc (reset_pc)
  ) decode_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .flush_i       (branch_taken_o),
    .target_i      (branch_target_o),
    .valid_o       (dec_valid),
    .pc_o          (dec_pc),
    .alu_op_o      (dec_alu_op),
    .rd_o          (dec_rd),
    .rs1_o         (dec_rs1),
    .rs2_o         (dec_rs2),
    .imm_o         (dec_imm),
    .imm_sel_o     (dec_imm_sel),
    .branch_o      (dec_branch),
    .cond_o        (dec_cond)
  );

  rv_regfile regfile_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .we_i     (rf_we),
    .waddr_i  (wb_rd_o),
    .wdata_i  (wb_data_o),
    .raddr1_i (rf_raddr1),
    .raddr2_i (rf_raddr2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2)
  );

  rv_opfetch opfetch_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (branch_taken_o),
    .valid_i     (dec_valid),
    .alu_op_i    (dec_alu_op),
    .rd_i        (dec_rd),
    .rs1_i       (dec_rs1),
    .rs2_i       (dec_rs2),
    .imm_i       (dec_imm),
    .imm_sel_i   (dec_imm_sel),
    .branch_i    (dec_branch),
    .cond_i      (dec_cond),
    .pc_i        (dec_pc),
    .rdata1_i    (rf_rdata1),
    .rdata2_i    (rf_rdata2),
    .ex_valid_i  (ex_valid),
    .ex_rd_i     (ex_rd),
    .ex_result_i (ex_result),
    .wb_rd_i     (wb_rd_o),
    .wb_data_i   (wb_data_o),
    .valid_o     (of_valid),
    .op_a_o      (of_op_a),
    .op_b_o      (of_op_b),
    .alu_op_o    (of_alu_op),
    .rd_o        (of_rd),
    .branch_o    (of_branch),
    .cond_o      (of_cond),
    .pc_o        (of_pc),
    .imm_o       (of_imm),
    .raddr1_o    (rf_raddr1),
    .raddr2_o    (rf_raddr2)
  );

  rv_alu alu_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (branch_taken_o),
    .valid_i       (of_valid),
    .op_a_i        (of_op_a),
    .op_b_i        (of_op_b),
    .alu_op_i      (of_alu_op),
    .rd_i          (of_rd),
    .branch_i      (of_branch),
    .cond_i        (of_cond),
    .pc_i          (of_pc),
    .imm_i         (of_imm),
    .valid_o       (ex_valid),
    .result_o      (ex_result),
    .equal_o       (ex_equal),
    .less_o        (ex_less),
    .less_signed_o (ex_less_signed),
    .rd_o          (ex_rd),
    .branch_o      (ex_branch),
    .cond_o        (ex_cond),
    .pc_o          (ex_pc),
    .imm_o         (ex_imm)
  );

  rv_writeback writeback_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .valid_i         (ex_valid),
    .result_i        (ex_result),
    .equal_i         (ex_equal),
    .less_i          (ex_less),
    .less_signed_i   (ex_less_signed),
    .rd_i            (ex_rd),
    .branch_i        (ex_branch),
    .cond_i          (ex_cond),
    .pc_i            (ex_pc),
    .imm_i           (ex_imm),
    .wb_valid_o      (wb_valid_o),
    .wb_pc_o         (wb_pc_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o),
    .reg_we_o        (rf_we),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

endmodule

//--- rv_clock_gen.sv
`timescale 1ns/1ps

module rv_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset seen high at the first two rising edges
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

//--- rv_core_asserts.sv
`timescale 1ns/1ps

module rv_core_asserts (
  input logic clk_i,
  input logic reset_i,
  input logic wb_valid_i,
  input logic branch_taken_i
);

  // Report outputs come out of reset low
  reset_quiet: assert property (
    @(posedge clk_i) reset_i |=> (!wb_valid_i && !branch_taken_i)
  ) else $error("wb_valid_o or branch_taken_o high after a reset edge");

  // A taken branch is always a retirement
  taken_with_valid: assert property (
    @(posedge clk_i) disable iff (reset_i) branch_taken_i |-> wb_valid_i
  ) else $error("branch_taken_o high without wb_valid_o");

  // Flush squashes the next report, so no back-to-back taken branches
  taken_single: assert property (
    @(posedge clk_i) disable iff (reset_i) branch_taken_i |=> !branch_taken_i
  ) else $error("branch_taken_o high in two consecutive cycles");

endmodule

bind rv_core rv_core_asserts rv_core_asserts_i (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .wb_valid_i     (wb_valid_o),
  .branch_taken_i (branch_taken_o)
);

//--- rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb
  import rv_pkg::*;
();

  localparam int              num_instr      = 2000;
  localparam int              timeout_cycles = num_instr * 3 / 2;
  localparam int              seed           = 56;
  localparam logic [xlen-1:0] tb_reset_pc    = 32'h0000_0100;

  logic                  clk_i;
  logic                  reset_i;
  logic                  instr_valid_i;
  logic [xlen-1:0]       instr_i;
  logic                  wb_valid_o;
  logic [xlen-1:0]       wb_pc_o;
  logic [reg_addr_w-1:0] wb_rd_o;
  logic [xlen-1:0]       wb_data_o;
  logic                  branch_taken_o;
  logic [xlen-1:0]       branch_target_o;

  // Reference model state
  logic [xlen-1:0] regs [0:31];
  logic [xlen-1:0] model_pc;
  logic            strobe_v [0:4095];
  logic [xlen-1:0] strobe_word [0:4095];
  int              squash_until;
  int              retired;
  int              cycles = 0;

  rv_clock_gen clock_gen_i (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  rv_core #(
    .reset_pc (tb_reset_pc)
  ) rv_core_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .wb_valid_o      (wb_valid_o),
    .wb_pc_o         (wb_pc_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

  task automatic check_value(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] expected);
    if (got !== expected) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, expected);
      $display("** FAIL **");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // RV32I integer ops with alt selecting SUB and SRA
  function automatic logic [xlen-1:0] alu_result(input logic [2:0] f3, input logic alt,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
    logic [4:0]      sh;
    logic [xlen-1:0] res;
    sh = b[4:0];
    case (f3)
      3'b000:  res = alt ? a - b : a + b;
      3'b001:  res = a << sh;
      3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  res = (a < b) ? 32'd1 : 32'd0;
      3'b100:  res = a ^ b;
      3'b101:  res = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic branch_decision(input logic [2:0] f3, input logic [xlen-1:0] a,
                                           input logic [xlen-1:0] b);
    logic res;
    case (f3)
      3'b000:  res = (a == b);
      3'b001:  res = (a != b);
      3'b100:  res = ($signed(a) < $signed(b));
      3'b101:  res = ($signed(a) >= $signed(b));
      3'b110:  res = (a < b);
      default: res = (a >= b);
    endcase
    return res;
  endfunction

  task automatic execute(input logic [xlen-1:0] instr, input logic [xlen-1:0] pc,
                         output logic [reg_addr_w-1:0] rd, output logic [xlen-1:0] data,
                         output logic taken, output logic [xlen-1:0] target);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [2:0]      f3;
    a      = regs[instr[19:15]];
    b      = regs[instr[24:20]];
    f3     = instr[14:12];
    imm_i  = {{20{instr[31]}}, instr[31:20]};
    imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    rd     = instr[11:7];
    data   = '0;
    taken  = 1'b0;
    target = '0;
    case (instr[6:0])
      7'b0110011: data = alu_result(f3, instr[30], a, b);
      7'b0010011: data = alu_result(f3, instr[30] && f3 == 3'b101, a, imm_i);
      7'b0110111: data = {instr[31:12], 12'b0};
      7'b1100011: begin
        rd     = '0;
        taken  = branch_decision(f3, a, b);
        target = pc + imm_b;
      end
      default: rd = '0;
    endcase
  endtask

  // Weighted mix over the supported encodings on registers x0 to x7
  function automatic logic [xlen-1:0] random_instr();
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [2:0]  idx;
    logic        alt;
    logic [11:0] imm12;
    logic [12:0] boff;
    logic [6:0]  opc;
    logic [31:0] word;
    kind  = $urandom_range(99);
    rd    = 5'($urandom_range(7));
    rs1   = 5'($urandom_range(7));
    rs2   = 5'($urandom_range(7));
    f3    = 3'($urandom_range(7));
    imm12 = 12'($urandom());
    alt   = ($urandom_range(1) == 1);
    if (kind < 35) begin
      alt  = alt && (f3 == 3'b000 || f3 == 3'b101);
      word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    end else if (kind < 65) begin
      if (f3 == 3'b001) begin
        imm12 = {7'b0, imm12[4:0]};
      end else if (f3 == 3'b101) begin
        imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
      end
      word = {imm12, rs1, f3, rd, 7'b0010011};
    end else if (kind < 75) begin
      word = {20'($urandom()), rd, 7'b0110111};
    end else if (kind < 92) begin
      idx  = 3'($urandom_range(5));
      f3   = (idx < 3'd2) ? idx : idx + 3'd2;
      // Small even offsets
      boff = 13'(2 * ($urandom_range(30) - 15));
      word = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
    end else begin
      case ($urandom_range(6))
        0:       opc = 7'b0000011;
        1:       opc = 7'b0100011;
        2:       opc = 7'b1101111;
        3:       opc = 7'b1100111;
        4:       opc = 7'b0010111;
        5:       opc = 7'b0001111;
        default: opc = 7'b1110011;
      endcase
      word = {25'($urandom()), opc};
    end
    return word;
  endfunction

  // Compares the outputs against the strobe made four edges earlier
  task automatic check_retirement(input int idx);
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic                  taken;
    logic [xlen-1:0]       target;
    if (idx >= 0 && strobe_v[idx] && idx > squash_until) begin
      execute(strobe_word[idx], model_pc, rd, data, taken, target);
      check_value("wb_valid_o", 32'(wb_valid_o), 32'd1);
      check_value("wb_pc_o", wb_pc_o, model_pc);
      check_value("wb_rd_o", 32'(wb_rd_o), 32'(rd));
      if (rd != '0) begin
        check_value("wb_data_o", wb_data_o, data);
        regs[rd] = data;
      end
      check_value("branch_taken_o", 32'(branch_taken_o), 32'(taken));
      if (taken) begin
        check_value("branch_target_o", branch_target_o, target);
        model_pc     = target;
        squash_until = idx + 4;
      end else begin
        model_pc = model_pc + 32'd4;
      end
      retired++;
    end else begin
      check_value("wb_valid_o", 32'(wb_valid_o), 32'd0);
      check_value("branch_taken_o", 32'(branch_taken_o), 32'd0);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int              n;
    int              issued;
    int              last_edge;
    logic [xlen-1:0] word;
    word          = $urandom(seed);
    instr_valid_i = 1'b0;
    instr_i       = '0;
    model_pc      = tb_reset_pc;
    squash_until  = -1;
    retired       = 0;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int e = 0; e < 4096; e++) begin
      strobe_v[e] = 1'b0;
    end
    n         = 0;
    issued    = 0;
    last_edge = -8;
    wait (!reset_i);
    while (issued < num_instr || n <= last_edge + 4) begin
      @(negedge clk_i);
      check_retirement(n - 4);
      if (issued < num_instr && $urandom_range(99) < 72) begin
        word           = random_instr();
        strobe_v[n]    = 1'b1;
        strobe_word[n] = word;
        instr_valid_i  = 1'b1;
        instr_i        = word;
        issued++;
        last_edge = n;
      end else begin
        instr_valid_i = 1'b0;
        instr_i       = $urandom();
      end
      n++;
    end
    instr_valid_i = 1'b0;
    $display("%0d of %0d instructions retired", retired, issued);
    $display("** PASS **");
    $finish;
  end

  // Guard against a run that never drains
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("** FAIL **");
      $fatal(1, "Timeout");
    end
  end

endmodule

//--- rv_core.f
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_opfetch.sv
rv_alu.sv
rv_writeback.sv
rv_core.sv
rv_clock_gen.sv
rv_core_asserts.sv
rv_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = rv_core.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed"; exit 1; \
	elif grep -qF '** PASS **' $(LOG); then echo "Simulation passed"; \
	else echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
